// File: ss_pkg.sv
`default_nettype none

package ss_pkg;

  // Widths with a meaning
  typedef logic [31:0] word_t;
  typedef logic [7:0]  ss_addr_t;

  // Number of state words in the core
  localparam int SS_WORDS = 16;

  // Bridge window, 0x4xxxxxxx below the byte length of the state
  localparam logic [3:0]  SS_WINDOW_TAG   = 4'h4;
  localparam logic [27:0] SS_WINDOW_BYTES = 28'(SS_WORDS * 4);

  // Cycles spent on one address before bus_out is taken
  localparam int SS_READ_WAIT = 10;

  // Core model safe point period
  localparam int SS_SAFE_PERIOD = 8;

  // Load FIFO depth
  localparam int SS_FIFO_DEPTH = 4;

  typedef enum logic [3:0] {
    init,
    save_busy,
    save_data,
    save_wait_read,
    load_data,
    load_delay,
    load_wait_host,
    load_busy_host,
    load_done_host
  } ctrl_state_t;

  // Bridge is big endian by nibble
  function automatic word_t nibble_swap(input word_t w);
    word_t r;
    for (int i = 0; i < 8; i++) begin
      r[4*i +: 4] = w[4*(7-i) +: 4];
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// File: ss_load_fifo.sv
`default_nettype none

module ss_load_fifo (
  input  wire                clk_sys,
  input  wire                reset,
  input  wire                bridge_wr,
  input  wire ss_pkg::word_t bridge_addr,
  input  wire ss_pkg::word_t bridge_wr_data,
  input  wire                fifo_pop,
  output ss_pkg::word_t      load_data,
  output logic               fifo_empty
);

  localparam int PTR_W = $clog2(ss_pkg::SS_FIFO_DEPTH);

  ss_pkg::word_t    mem [ss_pkg::SS_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             in_window;
  logic             do_push;
  logic             do_pop;

  assign in_window = (bridge_addr[31:28] == ss_pkg::SS_WINDOW_TAG) &&
                     (bridge_addr[27:0] < ss_pkg::SS_WINDOW_BYTES);

  // Full pushes and empty pops are dropped
  assign do_push = bridge_wr && in_window && (count != (PTR_W+1)'(ss_pkg::SS_FIFO_DEPTH));
  assign do_pop  = fifo_pop && (count != '0);

  assign fifo_empty = (count == '0);

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage and output word, no show-ahead
  always_ff @(posedge clk_sys) begin
    if (do_push) begin
      mem[wr_ptr] <= ss_pkg::nibble_swap(bridge_wr_data);
    end
    if (do_pop) begin
      load_data <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// File: ss_save_buffer.sv
`default_nettype none

module ss_save_buffer (
  input  wire                clk_sys,
  input  wire                reset,
  input  wire                buf_write,
  input  wire ss_pkg::word_t bus_out,
  input  wire                bridge_rd,
  input  wire ss_pkg::word_t bridge_addr,
  output ss_pkg::word_t      read_data,
  output logic               buf_empty
);

  ss_pkg::word_t data;
  logic          full;
  logic          in_window;

  assign in_window = (bridge_addr[31:28] == ss_pkg::SS_WINDOW_TAG) &&
                     (bridge_addr[27:0] < ss_pkg::SS_WINDOW_BYTES);

  // Full flag, a capture wins over a release in the same cycle
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      full <= 1'b0;
    end else if (buf_write) begin
      full <= 1'b1;
    end else if (bridge_rd && in_window) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (buf_write) begin
      data <= bus_out;
    end
  end

  assign read_data = ss_pkg::nibble_swap(data);
  assign buf_empty = !full;

endmodule

`default_nettype wire

// File: save_state_controller.sv
`default_nettype none

module save_state_controller (
  input  wire                  clk_sys,
  input  wire                  reset,

  // Host requests and status
  input  wire                  savestate_start,
  output logic                 savestate_start_ack,
  output logic                 savestate_start_busy,
  output logic                 savestate_start_ok,
  output logic                 savestate_start_err,
  input  wire                  savestate_load,
  output logic                 savestate_load_ack,
  output logic                 savestate_load_busy,
  output logic                 savestate_load_ok,
  output logic                 savestate_load_err,

  // Load FIFO and save buffer
  input  wire                  fifo_empty,
  output logic                 fifo_pop,
  input  wire ss_pkg::word_t   load_data,
  input  wire                  buf_empty,
  output logic                 buf_write,

  // Savestate bus
  output ss_pkg::ss_addr_t     bus_addr,
  output ss_pkg::word_t        bus_in,
  output logic                 bus_wren,
  output logic                 bus_reset,
  input  wire                  ss_ready,
  output logic                 ss_halt,
  output logic                 ss_reset
);

  localparam ss_pkg::ss_addr_t LAST_ADDR = ss_pkg::ss_addr_t'(ss_pkg::SS_WORDS - 1);
  localparam logic [3:0] CAPTURE_CNT = 4'(ss_pkg::SS_READ_WAIT - 1);
  localparam logic [3:0] ADVANCE_CNT = 4'(ss_pkg::SS_READ_WAIT);

  ss_pkg::ctrl_state_t state;
  logic [3:0]          cycle_count;

  // Never raised
  assign savestate_start_err = 1'b0;
  assign savestate_load_err  = 1'b0;

  // FIFO head goes straight onto the bus
  assign bus_in = load_data;

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      state                <= ss_pkg::init;
      cycle_count          <= '0;
      bus_addr             <= '0;
      bus_wren             <= 1'b0;
      bus_reset            <= 1'b1;
      ss_halt              <= 1'b0;
      ss_reset             <= 1'b0;
      fifo_pop             <= 1'b0;
      buf_write            <= 1'b0;
      savestate_start_ack  <= 1'b0;
      savestate_start_busy <= 1'b0;
      savestate_start_ok   <= 1'b0;
      savestate_load_ack   <= 1'b0;
      savestate_load_busy  <= 1'b0;
      savestate_load_ok    <= 1'b0;
    end else begin
      case (state)
        ss_pkg::init: begin
          ss_halt   <= 1'b0;
          ss_reset  <= 1'b0;
          bus_reset <= 1'b0;
          bus_addr  <= '0;
          if (savestate_start) begin
            state                <= ss_pkg::save_busy;
            savestate_start_ack  <= 1'b1;
            savestate_start_busy <= 1'b0;
            savestate_start_ok   <= 1'b0;
            savestate_load_ok    <= 1'b0;
          end else if (!fifo_empty) begin
            // Host began writing a state; wraps to 0 on the first write
            state    <= ss_pkg::load_data;
            bus_addr <= '1;
            ss_halt  <= 1'b1;
          end
        end

        ss_pkg::save_busy: begin
          savestate_start_ack  <= 1'b0;
          savestate_start_busy <= 1'b1;
          // Wait for a safe point in the core
          if (ss_ready) begin
            state                <= ss_pkg::save_data;
            bus_addr             <= '0;
            ss_halt              <= 1'b1;
            cycle_count          <= '0;
            savestate_start_busy <= 1'b0;
            savestate_start_ok   <= 1'b1;
          end
        end

        ss_pkg::save_data: begin
          buf_write   <= 1'b0;
          cycle_count <= cycle_count + 4'h1;
          if (cycle_count == CAPTURE_CNT) begin
            buf_write <= 1'b1;
          end else if (cycle_count == ADVANCE_CNT) begin
            cycle_count <= '0;
            bus_addr    <= bus_addr + 8'h1;
            if (bus_addr == LAST_ADDR) begin
              state <= ss_pkg::init;
            end else begin
              state <= ss_pkg::save_wait_read;
            end
          end
        end

        // Hold until the host has read the buffer
        ss_pkg::save_wait_read: begin
          if (buf_empty) begin
            state <= ss_pkg::save_data;
          end
        end

        ss_pkg::load_data: begin
          bus_wren <= 1'b0;
          if (bus_addr == LAST_ADDR) begin
            state <= ss_pkg::load_wait_host;
          end else if (!fifo_empty) begin
            state    <= ss_pkg::load_delay;
            fifo_pop <= 1'b1;
          end
        end

        // Popped word is valid next cycle, write it then
        ss_pkg::load_delay: begin
          state    <= ss_pkg::load_data;
          fifo_pop <= 1'b0;
          bus_addr <= bus_addr + 8'h1;
          bus_wren <= 1'b1;
        end

        ss_pkg::load_wait_host: begin
          if (savestate_load) begin
            state               <= ss_pkg::load_busy_host;
            savestate_load_ack  <= 1'b1;
            savestate_load_busy <= 1'b0;
            savestate_load_ok   <= 1'b0;
            savestate_start_ok  <= 1'b0;
            ss_reset            <= 1'b1;
          end
        end

        ss_pkg::load_busy_host: begin
          state               <= ss_pkg::load_done_host;
          savestate_load_ack  <= 1'b0;
          savestate_load_busy <= 1'b1;
        end

        ss_pkg::load_done_host: begin
          state               <= ss_pkg::init;
          savestate_load_busy <= 1'b0;
          savestate_load_ok   <= 1'b1;
        end

        default: begin
          state <= ss_pkg::init;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: ss_core_state.sv
`default_nettype none

module ss_core_state (
  input  wire                   clk_sys,
  input  wire                   reset,
  input  wire ss_pkg::ss_addr_t bus_addr,
  input  wire ss_pkg::word_t    bus_in,
  input  wire                   bus_wren,
  input  wire                   bus_reset,
  output ss_pkg::word_t         bus_out,
  input  wire                   ss_halt,
  input  wire                   ss_reset,
  output logic                  ss_ready
);

  localparam int IDX_W  = $clog2(ss_pkg::SS_WORDS);
  localparam int SAFE_W = $clog2(ss_pkg::SS_SAFE_PERIOD);
  localparam logic [SAFE_W-1:0] SAFE_LAST = SAFE_W'(ss_pkg::SS_SAFE_PERIOD - 1);

  ss_pkg::word_t     regs [ss_pkg::SS_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              addr_ok;
  logic [SAFE_W-1:0] safe_cnt;

  assign idx     = bus_addr[IDX_W-1:0];
  assign addr_ok = (bus_addr < ss_pkg::ss_addr_t'(ss_pkg::SS_WORDS));

  // State registers, bus_reset loads the defaults
  always_ff @(posedge clk_sys) begin
    if (bus_reset) begin
      for (int i = 0; i < ss_pkg::SS_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (bus_wren && addr_ok) begin
      regs[idx] <= bus_in;
    end
  end

  // Unmapped addresses read as zero
  assign bus_out = addr_ok ? regs[idx] : '0;

  // Safe point counter, frozen while halted
  always_ff @(posedge clk_sys) begin
    if (reset || ss_reset) begin
      safe_cnt <= '0;
    end else if (!ss_halt) begin
      if (safe_cnt == SAFE_LAST) begin
        safe_cnt <= '0;
      end else begin
        safe_cnt <= safe_cnt + 1'b1;
      end
    end
  end

  assign ss_ready = (safe_cnt == SAFE_LAST) && !ss_halt;

endmodule

`default_nettype wire

// File: save_state_top.sv
`default_nettype none

module save_state_top (
  input  wire                clk_sys,
  input  wire                reset,

  // Bridge
  input  wire                bridge_wr,
  input  wire                bridge_rd,
  input  wire ss_pkg::word_t bridge_addr,
  input  wire ss_pkg::word_t bridge_wr_data,
  output ss_pkg::word_t      bridge_rd_data,

  // Host savestate status
  input  wire                savestate_load,
  output logic               savestate_load_ack,
  output logic               savestate_load_busy,
  output logic               savestate_load_ok,
  output logic               savestate_load_err,
  input  wire                savestate_start,
  output logic               savestate_start_ack,
  output logic               savestate_start_busy,
  output logic               savestate_start_ok,
  output logic               savestate_start_err
);

  wire                   fifo_pop;
  wire                   fifo_empty;
  wire ss_pkg::word_t    load_data;
  wire                   buf_write;
  wire                   buf_empty;
  wire ss_pkg::ss_addr_t bus_addr;
  wire ss_pkg::word_t    bus_in;
  wire ss_pkg::word_t    bus_out;
  wire                   bus_wren;
  wire                   bus_reset;
  wire                   ss_ready;
  wire                   ss_halt;
  wire                   ss_reset;

  ss_load_fifo u_load_fifo (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .fifo_pop       (fifo_pop),
    .load_data      (load_data),
    .fifo_empty     (fifo_empty)
  );

  ss_save_buffer u_save_buffer (
    .clk_sys     (clk_sys),
    .reset       (reset),
    .buf_write   (buf_write),
    .bus_out     (bus_out),
    .bridge_rd   (bridge_rd),
    .bridge_addr (bridge_addr),
    .read_data   (bridge_rd_data),
    .buf_empty   (buf_empty)
  );

  save_state_controller u_controller (
    .clk_sys              (clk_sys),
    .reset                (reset),
    .savestate_start      (savestate_start),
    .savestate_start_ack  (savestate_start_ack),
    .savestate_start_busy (savestate_start_busy),
    .savestate_start_ok   (savestate_start_ok),
    .savestate_start_err  (savestate_start_err),
    .savestate_load       (savestate_load),
    .savestate_load_ack   (savestate_load_ack),
    .savestate_load_busy  (savestate_load_busy),
    .savestate_load_ok    (savestate_load_ok),
    .savestate_load_err   (savestate_load_err),
    .fifo_empty           (fifo_empty),
    .fifo_pop             (fifo_pop),
    .load_data            (load_data),
    .buf_empty            (buf_empty),
    .buf_write            (buf_write),
    .bus_addr             (bus_addr),
    .bus_in               (bus_in),
    .bus_wren             (bus_wren),
    .bus_reset            (bus_reset),
    .ss_ready             (ss_ready),
    .ss_halt              (ss_halt),
    .ss_reset             (ss_reset)
  );

  ss_core_state u_core_state (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .bus_addr  (bus_addr),
    .bus_in    (bus_in),
    .bus_wren  (bus_wren),
    .bus_reset (bus_reset),
    .bus_out   (bus_out),
    .ss_halt   (ss_halt),
    .ss_reset  (ss_reset),
    .ss_ready  (ss_ready)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk_sys,
  output logic reset
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_sys = 1'b0;
    forever #HALF_PERIOD clk_sys = ~clk_sys;
  end

  // Released on a falling edge like the other DUT inputs
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_sys);
    @(negedge clk_sys);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_save_state.sv
`default_nettype none

module tb_save_state;

  localparam int NUM_WORDS      = ss_pkg::SS_WORDS;
  localparam int READ_SPACING   = 16;
  localparam int WRITE_GAP      = 3;
  localparam int STATUS_WAIT    = 50;
  localparam int TIMEOUT_CYCLES = 3 * 16 * 40 + 500;
  localparam logic [31:0] WINDOW_BASE = 32'h4000_0000;

  // Bit positions in the status vector
  localparam int LOAD_ACK   = 0;
  localparam int LOAD_BUSY  = 1;
  localparam int LOAD_OK    = 2;
  localparam int START_ACK  = 4;
  localparam int START_OK   = 6;

  wire         clk_sys;
  wire         reset;
  logic        bridge_wr;
  logic        bridge_rd;
  logic [31:0] bridge_addr;
  logic [31:0] bridge_wr_data;
  wire  [31:0] bridge_rd_data;
  logic        savestate_load;
  logic        savestate_start;
  wire         savestate_load_ack;
  wire         savestate_load_busy;
  wire         savestate_load_ok;
  wire         savestate_load_err;
  wire         savestate_start_ack;
  wire         savestate_start_busy;
  wire         savestate_start_ok;
  wire         savestate_start_err;
  wire  [7:0]  status;

  // Words the core should hold after the bridge swap
  logic [31:0] core_model [NUM_WORDS];
  logic [31:0] rng_state;
  int          cycle_count   = 0;

  assign status = {savestate_start_err, savestate_start_ok, savestate_start_busy,
                   savestate_start_ack, savestate_load_err, savestate_load_ok,
                   savestate_load_busy, savestate_load_ack};

  tb_clock_gen u_clock_gen (
    .clk_sys (clk_sys),
    .reset   (reset)
  );

  save_state_top u_dut (
    .clk_sys              (clk_sys),
    .reset                (reset),
    .bridge_wr            (bridge_wr),
    .bridge_rd            (bridge_rd),
    .bridge_addr          (bridge_addr),
    .bridge_wr_data       (bridge_wr_data),
    .bridge_rd_data       (bridge_rd_data),
    .savestate_load       (savestate_load),
    .savestate_load_ack   (savestate_load_ack),
    .savestate_load_busy  (savestate_load_busy),
    .savestate_load_ok    (savestate_load_ok),
    .savestate_load_err   (savestate_load_err),
    .savestate_start      (savestate_start),
    .savestate_start_ack  (savestate_start_ack),
    .savestate_start_busy (savestate_start_busy),
    .savestate_start_ok   (savestate_start_ok),
    .savestate_start_err  (savestate_start_err)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Lowest nibble ends up on top
  function automatic logic [31:0] reverse_nibbles(input logic [31:0] w);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < 8; i++) begin
      r = (r << 4) | ((w >> (4 * i)) & 32'hf);
    end
    return r;
  endfunction

  // Read data goes through a second swap on the way out
  function automatic logic [31:0] expected_read_word(input int idx);
    return reverse_nibbles(core_model[idx]);
  endfunction

  function automatic logic in_window(input logic [31:0] addr);
    return (addr[31:28] == 4'h4) && (addr[27:0] < 28'(NUM_WORDS * 4));
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk_sys);
  endtask

  // Bridge strobes start on the current falling edge
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_sys);
    bridge_wr = 1'b0;
  endtask

  task automatic read_word(input int idx);
    bridge_addr = WINDOW_BASE + 32'(idx * 4);
    bridge_rd   = 1'b1;
    @(negedge clk_sys);
    bridge_rd = 1'b0;
  endtask

  task automatic wait_status(input int bit_idx, input string name);
    int waited;
    waited = 0;
    while (status[bit_idx] !== 1'b1) begin
      assert (waited < STATUS_WAIT)
        else report_failure($sformatf("Timed out after %0d cycles waiting for %s",
                                      STATUS_WAIT, name));
      @(negedge clk_sys);
      waited++;
    end
  endtask

  task automatic load_words(input bit add_stray);
    logic [31:0] data;
    for (int i = 0; i < NUM_WORDS; i++) begin
      rng_state = xorshift32(rng_state);
      data = rng_state;
      core_model[i] = reverse_nibbles(data);
      write_word(WINDOW_BASE + 32'(i * 4), data);
      idle(WRITE_GAP);
      if (add_stray) begin
        // Wrong tag on even words, offset past the window on odd ones
        if (i % 2 == 0) begin
          write_word(32'h5000_0000 + 32'(i * 4), ~data);
        end else begin
          write_word(WINDOW_BASE + 32'((NUM_WORDS + i / 2) * 4), ~data);
        end
        idle(WRITE_GAP);
      end
    end
  endtask

  task automatic finish_load();
    savestate_load = 1'b1;
    wait_status(LOAD_ACK, "savestate_load_ack");
    savestate_load = 1'b0;
    wait_status(LOAD_BUSY, "savestate_load_busy");
    wait_status(LOAD_OK, "savestate_load_ok");
    // ok holds until a save starts
    repeat (20) begin
      @(negedge clk_sys);
      assert (savestate_load_ok === 1'b1)
        else report_failure($sformatf("FAIL savestate_load_ok: got %h expected 1",
                                      savestate_load_ok));
    end
  endtask

  task automatic start_save();
    savestate_start = 1'b1;
    wait_status(START_ACK, "savestate_start_ack");
    savestate_start = 1'b0;
    wait_status(START_OK, "savestate_start_ok");
    assert (savestate_load_ok === 1'b0)
      else report_failure($sformatf("FAIL savestate_load_ok: got %h expected 0",
                                    savestate_load_ok));
  endtask

  task automatic save_and_check(input int stall_cycles);
    start_save();
    idle(READ_SPACING);
    for (int i = 0; i < NUM_WORDS; i++) begin
      // Host holds off on two of the words
      if (i == 0 || i == NUM_WORDS / 2) begin
        idle(stall_cycles);
      end
      read_word(i);
      idle(READ_SPACING - 1);
    end
  endtask

  // Compare every window read against the model
  always @(posedge clk_sys) begin
    if (!reset && bridge_rd && in_window(bridge_addr)) begin
      assert (bridge_rd_data === expected_read_word(int'(bridge_addr[5:2])))
        else report_failure($sformatf("FAIL bridge_rd_data word %0d: got %08h expected %08h",
                                      bridge_addr[5:2], bridge_rd_data,
                                      expected_read_word(int'(bridge_addr[5:2]))));
    end
  end

  // Run limit and err watch
  always @(posedge clk_sys) begin
    cycle_count <= cycle_count + 1;
    assert (cycle_count < TIMEOUT_CYCLES)
      else report_failure($sformatf("Simulation timed out after %0d cycles", TIMEOUT_CYCLES));
    assert (savestate_start_err === 1'b0)
      else report_failure($sformatf("FAIL savestate_start_err: got %h expected 0",
                                    savestate_start_err));
    assert (savestate_load_err === 1'b0)
      else report_failure($sformatf("FAIL savestate_load_err: got %h expected 0",
                                    savestate_load_err));
  end

  initial begin
    bridge_wr       = 1'b0;
    bridge_rd       = 1'b0;
    bridge_addr     = '0;
    bridge_wr_data  = '0;
    savestate_load  = 1'b0;
    savestate_start = 1'b0;
    rng_state       = 32'd89;
    for (int i = 0; i < NUM_WORDS; i++) begin
      core_model[i] = '0;
    end
    @(negedge clk_sys);
    while (reset) begin
      @(negedge clk_sys);
    end

    // Idle status, then a save of the cleared core
    assert (status === 8'h00)
      else report_failure($sformatf("FAIL status outputs: got %02h expected 00", status));
    save_and_check(0);

    // Load random words, then save them back
    load_words(1'b0);
    finish_load();
    save_and_check(0);

    // Second load with stray writes around the window
    load_words(1'b1);
    finish_load();
    save_and_check(0);

    // Host stalls the reads
    save_and_check(100);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
ss_pkg.sv
ss_load_fifo.sv
ss_save_buffer.sv
save_state_controller.sv
ss_core_state.sv
save_state_top.sv
tb_clock_gen.sv
tb_save_state.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_save_state \
  -f src.f -o sim_save_state > build.log 2>&1 &&
  ./obj_dir/sim_save_state 2>&1 | tee sim.log ||
  echo "Build or simulation exited with an error"
grep -qx "Finished with no errors" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
